// ==== source/core_perf_consts.svh ====
/*
 * Widths, lane count and DCR map for the performance monitor.
 * All counters share one width and wrap silently on overflow.
 * DCACHE_NUM_REQS must stay at or below 7 to fit the 3-bit lane count.
 */
`ifndef CORE_PERF_CONSTS_SVH
`define CORE_PERF_CONSTS_SVH

// Counter width
`define PERF_CTR_BITS 44

// Data cache request lanes
`define DCACHE_NUM_REQS 4

// DCR write bus
`define DCR_ADDR_WIDTH 12
`define DCR_DATA_WIDTH 32

// Recognized DCR addresses
`define DCR_STARTUP_ADDR 12'h001
`define DCR_STARTUP_ARG  12'h002

// Boot vector after reset
`define STARTUP_ADDR_RESET 32'h80000000

`endif

// ==== source/core_perf_pkg.sv ====
/*
 * Shared types for the performance monitor.
 * Widths follow the constants header, so the header must be on the include path.
 */
`include "core_perf_consts.svh"

package core_perf_pkg;

    // Event and latency counters
    typedef logic [`PERF_CTR_BITS-1:0] perf_ctr_t;

    // DCR write bus fields
    typedef logic [`DCR_ADDR_WIDTH-1:0] dcr_addr_t;
    typedef logic [`DCR_DATA_WIDTH-1:0] dcr_data_t;

    // One bit per dcache lane
    typedef logic [`DCACHE_NUM_REQS-1:0] lane_vec_t;

    // Number of lanes firing in one cycle, 0 up to DCACHE_NUM_REQS
    typedef logic [$clog2(`DCACHE_NUM_REQS+1)-1:0] lane_cnt_t;

endpackage

// ==== source/dcr_regs.sv ====
/*
 * Startup registers loaded from the DCR write strobe.
 * The strobe has no ready; writes to unknown addresses are dropped.
 * New values are visible the cycle after the strobe.
 */
`timescale 1ns/100ps

`include "core_perf_consts.svh"

module dcr_regs (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      dcr_write_valid,
    input  core_perf_pkg::dcr_addr_t  dcr_write_addr,
    input  core_perf_pkg::dcr_data_t  dcr_write_data,

    output core_perf_pkg::dcr_data_t  startup_addr,
    output core_perf_pkg::dcr_data_t  startup_arg
);

    always_ff @(posedge clk) begin
        if (reset) begin
            startup_addr <= `STARTUP_ADDR_RESET;
            startup_arg  <= '0;
        end else if (dcr_write_valid) begin
            case (dcr_write_addr)
                `DCR_STARTUP_ADDR: begin
                    startup_addr <= dcr_write_data;
                end
                `DCR_STARTUP_ARG: begin
                    startup_arg <= dcr_write_data;
                end
                default: begin
                    // Unmapped address, nothing to load
                end
            endcase
        end
    end

endmodule

// ==== source/mem_fire_decode.sv ====
/*
 * Handshake decode for the icache port and the dcache lanes.
 * Purely combinational; counts are valid in the same cycle as the fires.
 * Only valid, ready and rw are observed, never driven.
 */
`timescale 1ns/100ps

`include "core_perf_consts.svh"

module mem_fire_decode (
    input  logic                      icache_req_valid,
    input  logic                      icache_req_ready,
    input  logic                      icache_rsp_valid,
    input  logic                      icache_rsp_ready,

    input  core_perf_pkg::lane_vec_t  dcache_req_valid,
    input  core_perf_pkg::lane_vec_t  dcache_req_rw,
    input  core_perf_pkg::lane_vec_t  dcache_req_ready,
    input  core_perf_pkg::lane_vec_t  dcache_rsp_valid,
    input  core_perf_pkg::lane_vec_t  dcache_rsp_ready,

    output logic                      icache_req_fire,
    output logic                      icache_rsp_fire,

    output core_perf_pkg::lane_cnt_t  dcache_rd_count,
    output core_perf_pkg::lane_cnt_t  dcache_wr_count,
    output core_perf_pkg::lane_cnt_t  dcache_rsp_count
);

    core_perf_pkg::lane_vec_t rd_fire;
    core_perf_pkg::lane_vec_t wr_fire;
    core_perf_pkg::lane_vec_t rsp_fire;

    function automatic core_perf_pkg::lane_cnt_t pop_count(
        input core_perf_pkg::lane_vec_t bits
    );
        core_perf_pkg::lane_cnt_t cnt;
        cnt = '0;
        for (int i = 0; i < `DCACHE_NUM_REQS; i++) begin
            cnt = cnt + core_perf_pkg::lane_cnt_t'(bits[i]);
        end
        return cnt;
    endfunction

    assign icache_req_fire = icache_req_valid & icache_req_ready;
    assign icache_rsp_fire = icache_rsp_valid & icache_rsp_ready;

    // Request fires split by rw, low is a load
    assign rd_fire  = dcache_req_valid & dcache_req_ready & ~dcache_req_rw;
    assign wr_fire  = dcache_req_valid & dcache_req_ready & dcache_req_rw;
    assign rsp_fire = dcache_rsp_valid & dcache_rsp_ready;

    assign dcache_rd_count  = pop_count(rd_fire);
    assign dcache_wr_count  = pop_count(wr_fire);
    assign dcache_rsp_count = pop_count(rsp_fire);

endmodule

// ==== source/pending_read_tracker.sv ====
/*
 * Outstanding read count and latency sum for one cache.
 * NUM_PORTS is 1 for the icache or DCACHE_NUM_REQS for the dcache.
 * Latency adds the pending count from before each edge, one cycle behind.
 * A response with nothing outstanding makes the pending count wrap.
 */
`timescale 1ns/100ps

`include "core_perf_consts.svh"

module pending_read_tracker #(
    parameter int NUM_PORTS = 1
) (
    input  logic                              clk,
    input  logic                              reset,

    input  logic [$clog2(NUM_PORTS+1)-1:0]    req_count,
    input  logic [$clog2(NUM_PORTS+1)-1:0]    rsp_count,

    output core_perf_pkg::perf_ctr_t          perf_latency
);

    localparam int CNT_W = $clog2(NUM_PORTS + 1);

    // One extra bit so the difference keeps its sign
    logic signed [CNT_W:0]               pending_delta;
    logic signed [`PERF_CTR_BITS-1:0]    pending_delta_ext;
    logic signed [`PERF_CTR_BITS-1:0]    pending_reads;

    assign pending_delta = $signed({1'b0, req_count}) - $signed({1'b0, rsp_count});

    assign pending_delta_ext = {{(`PERF_CTR_BITS-CNT_W-1){pending_delta[CNT_W]}},
                                pending_delta};

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reads <= '0;
            perf_latency  <= '0;
        end else begin
            pending_reads <= pending_reads + pending_delta_ext;
            perf_latency  <= perf_latency + core_perf_pkg::perf_ctr_t'(pending_reads);
        end
    end

endmodule

// ==== source/access_counters.sv ====
/*
 * Instruction fetch, load and store event counters.
 * Each counter shows a cycle's fires one cycle later.
 */
`timescale 1ns/100ps

module access_counters (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      icache_req_fire,
    input  core_perf_pkg::lane_cnt_t  dcache_rd_count,
    input  core_perf_pkg::lane_cnt_t  dcache_wr_count,

    output core_perf_pkg::perf_ctr_t  perf_ifetches,
    output core_perf_pkg::perf_ctr_t  perf_loads,
    output core_perf_pkg::perf_ctr_t  perf_stores
);

    core_perf_pkg::perf_ctr_t ifetch_inc;
    core_perf_pkg::perf_ctr_t load_inc;
    core_perf_pkg::perf_ctr_t store_inc;

    // Zero-extend the per-cycle counts to counter width
    assign ifetch_inc = core_perf_pkg::perf_ctr_t'(icache_req_fire);
    assign load_inc   = core_perf_pkg::perf_ctr_t'(dcache_rd_count);
    assign store_inc  = core_perf_pkg::perf_ctr_t'(dcache_wr_count);

    always_ff @(posedge clk) begin
        if (reset) begin
            perf_ifetches <= '0;
            perf_loads    <= '0;
            perf_stores   <= '0;
        end else begin
            perf_ifetches <= perf_ifetches + ifetch_inc;
            perf_loads    <= perf_loads + load_inc;
            perf_stores   <= perf_stores + store_inc;
        end
    end

endmodule

// ==== source/core_perf_top.sv ====
/*
 * Core wrapper slice: startup DCRs and the memory performance monitor.
 * The monitor is passive; every bus handshake signal is an input here.
 * Counter outputs are registered and lag the observed fires by one cycle.
 */
`timescale 1ns/100ps

`include "core_perf_consts.svh"

module core_perf_top (
    input  logic                      clk,
    input  logic                      reset,

    // DCR write strobe
    input  logic                      dcr_write_valid,
    input  core_perf_pkg::dcr_addr_t  dcr_write_addr,
    input  core_perf_pkg::dcr_data_t  dcr_write_data,

    // Icache handshakes
    input  logic                      icache_req_valid,
    input  logic                      icache_req_ready,
    input  logic                      icache_rsp_valid,
    input  logic                      icache_rsp_ready,

    // Dcache handshakes, one bit per lane
    input  core_perf_pkg::lane_vec_t  dcache_req_valid,
    input  core_perf_pkg::lane_vec_t  dcache_req_rw,
    input  core_perf_pkg::lane_vec_t  dcache_req_ready,
    input  core_perf_pkg::lane_vec_t  dcache_rsp_valid,
    input  core_perf_pkg::lane_vec_t  dcache_rsp_ready,

    output core_perf_pkg::dcr_data_t  startup_addr,
    output core_perf_pkg::dcr_data_t  startup_arg,

    output core_perf_pkg::perf_ctr_t  perf_ifetches,
    output core_perf_pkg::perf_ctr_t  perf_loads,
    output core_perf_pkg::perf_ctr_t  perf_stores,
    output core_perf_pkg::perf_ctr_t  perf_icache_latency,
    output core_perf_pkg::perf_ctr_t  perf_dcache_latency
);

    logic                      icache_req_fire;
    logic                      icache_rsp_fire;
    core_perf_pkg::lane_cnt_t  dcache_rd_count;
    core_perf_pkg::lane_cnt_t  dcache_wr_count;
    core_perf_pkg::lane_cnt_t  dcache_rsp_count;

    dcr_regs dcr_regs (
        .clk              (clk),
        .reset            (reset),
        .dcr_write_valid  (dcr_write_valid),
        .dcr_write_addr   (dcr_write_addr),
        .dcr_write_data   (dcr_write_data),
        .startup_addr     (startup_addr),
        .startup_arg      (startup_arg)
    );

    mem_fire_decode mem_fire_decode (
        .icache_req_valid  (icache_req_valid),
        .icache_req_ready  (icache_req_ready),
        .icache_rsp_valid  (icache_rsp_valid),
        .icache_rsp_ready  (icache_rsp_ready),
        .dcache_req_valid  (dcache_req_valid),
        .dcache_req_rw     (dcache_req_rw),
        .dcache_req_ready  (dcache_req_ready),
        .dcache_rsp_valid  (dcache_rsp_valid),
        .dcache_rsp_ready  (dcache_rsp_ready),
        .icache_req_fire   (icache_req_fire),
        .icache_rsp_fire   (icache_rsp_fire),
        .dcache_rd_count   (dcache_rd_count),
        .dcache_wr_count   (dcache_wr_count),
        .dcache_rsp_count  (dcache_rsp_count)
    );

    access_counters access_counters (
        .clk              (clk),
        .reset            (reset),
        .icache_req_fire  (icache_req_fire),
        .dcache_rd_count  (dcache_rd_count),
        .dcache_wr_count  (dcache_wr_count),
        .perf_ifetches    (perf_ifetches),
        .perf_loads       (perf_loads),
        .perf_stores      (perf_stores)
    );

    // Single fetch port, so counts are plain fire bits
    pending_read_tracker #(
        .NUM_PORTS  (1)
    ) icache_tracker (
        .clk           (clk),
        .reset         (reset),
        .req_count     (icache_req_fire),
        .rsp_count     (icache_rsp_fire),
        .perf_latency  (perf_icache_latency)
    );

    pending_read_tracker #(
        .NUM_PORTS  (`DCACHE_NUM_REQS)
    ) dcache_tracker (
        .clk           (clk),
        .reset         (reset),
        .req_count     (dcache_rd_count),
        .rsp_count     (dcache_rsp_count),
        .perf_latency  (perf_dcache_latency)
    );

endmodule

// ==== bench/core_perf_assert.sv ====
/*
 * Concurrent checks on the monitor counters, bound into core_perf_top.
 * Step checks are skipped in the first cycle after reset.
 */
`timescale 1ns/100ps

`include "core_perf_consts.svh"

module core_perf_assert (
    input  logic                      clk,
    input  logic                      reset,
    input  core_perf_pkg::perf_ctr_t  perf_ifetches,
    input  core_perf_pkg::perf_ctr_t  perf_loads,
    input  core_perf_pkg::perf_ctr_t  perf_stores,
    input  core_perf_pkg::perf_ctr_t  perf_icache_latency,
    input  core_perf_pkg::perf_ctr_t  perf_dcache_latency
);

    localparam core_perf_pkg::perf_ctr_t MAX_LOAD_STEP =
        core_perf_pkg::perf_ctr_t'(`DCACHE_NUM_REQS);

    // Reset edge clears every counter
    counters_zero_after_reset: assert property (@(posedge clk)
        $past(reset) |-> (perf_ifetches == '0 && perf_loads == '0 && perf_stores == '0
                          && perf_icache_latency == '0 && perf_dcache_latency == '0))
        else $error("counters not zero after reset");

    loads_step_bounded: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> ((perf_loads - $past(perf_loads)) <= MAX_LOAD_STEP))
        else $error("perf_loads rose by more than the lane count in one cycle");

    ifetches_monotonic: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (perf_ifetches >= $past(perf_ifetches)))
        else $error("perf_ifetches decreased outside reset");

endmodule

bind core_perf_top core_perf_assert perf_checks (
    .clk                  (clk),
    .reset                (reset),
    .perf_ifetches        (perf_ifetches),
    .perf_loads           (perf_loads),
    .perf_stores          (perf_stores),
    .perf_icache_latency  (perf_icache_latency),
    .perf_dcache_latency  (perf_dcache_latency)
);

// ==== bench/core_perf_tb.sv ====
/*
 * Table-driven testbench for core_perf_top with a cycle-level model.
 * Inputs change on the falling edge; outputs are compared on the next one.
 * Random rows hold responses behind outstanding reads, so pending never wraps.
 */
`timescale 1ns/100ps

`include "core_perf_consts.svh"

module core_perf_tb;

    typedef struct packed {
        logic                      dcr_valid;
        core_perf_pkg::dcr_addr_t  dcr_addr;
        core_perf_pkg::dcr_data_t  dcr_data;
        logic [31:0]               count;
        logic                      is_random;
        logic                      check_totals;
        logic [3:0]                ic;
        core_perf_pkg::lane_vec_t  dc_valid, dc_rw, dc_ready, dc_rsp_valid, dc_rsp_ready;
        logic [31:0]               e_ifetches, e_loads, e_stores, e_ilat, e_dlat;
        core_perf_pkg::dcr_data_t  e_addr, e_arg;
    } row_t;

    logic clk, reset;
    logic dcr_write_valid;
    core_perf_pkg::dcr_addr_t dcr_write_addr;
    core_perf_pkg::dcr_data_t dcr_write_data;
    logic icache_req_valid, icache_req_ready, icache_rsp_valid, icache_rsp_ready;
    core_perf_pkg::lane_vec_t dcache_req_valid, dcache_req_rw, dcache_req_ready;
    core_perf_pkg::lane_vec_t dcache_rsp_valid, dcache_rsp_ready;
    core_perf_pkg::dcr_data_t startup_addr, startup_arg;
    core_perf_pkg::perf_ctr_t perf_ifetches, perf_loads, perf_stores;
    core_perf_pkg::perf_ctr_t perf_icache_latency, perf_dcache_latency;

    row_t  rows[$];
    string row_names[$];
    logic [31:0] rng_state;
    int    error_count, check_count, test_count, total_cycles;
    longint watchdog_ns;
    logic  table_ready = 1'b0;

    // Reference model state, one edge ahead of the DUT while a cycle is driven
    core_perf_pkg::perf_ctr_t m_ifetches, m_loads, m_stores, m_ilat, m_dlat;
    core_perf_pkg::dcr_data_t m_startup_addr, m_startup_arg;
    int m_ipend, m_dpend;

    core_perf_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, expected);
        end
    endtask

    task automatic add_row(input string name, input logic dcr_valid,
                           input core_perf_pkg::dcr_addr_t dcr_addr,
                           input core_perf_pkg::dcr_data_t dcr_data, input int count,
                           input logic [3:0] ic, input core_perf_pkg::lane_vec_t dc_valid,
                           input core_perf_pkg::lane_vec_t dc_rw,
                           input core_perf_pkg::lane_vec_t dc_ready,
                           input core_perf_pkg::lane_vec_t dc_rsp_valid,
                           input core_perf_pkg::lane_vec_t dc_rsp_ready,
                           input int e_if, input int e_ld, input int e_st, input int e_il,
                           input int e_dl, input core_perf_pkg::dcr_data_t e_addr,
                           input core_perf_pkg::dcr_data_t e_arg);
        row_t r;
        r = '0;
        r.dcr_valid = dcr_valid;
        r.dcr_addr = dcr_addr;
        r.dcr_data = dcr_data;
        r.count = count;
        r.check_totals = 1'b1;
        r.ic = ic;
        r.dc_valid = dc_valid;
        r.dc_rw = dc_rw;
        r.dc_ready = dc_ready;
        r.dc_rsp_valid = dc_rsp_valid;
        r.dc_rsp_ready = dc_rsp_ready;
        r.e_ifetches = e_if;
        r.e_loads = e_ld;
        r.e_stores = e_st;
        r.e_ilat = e_il;
        r.e_dlat = e_dl;
        r.e_addr = e_addr;
        r.e_arg = e_arg;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    task automatic add_random(input string name, input int count);
        row_t r;
        r = '0;
        r.count = count;
        r.is_random = 1'b1;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    // ic bits are {req_valid, req_ready, rsp_valid, rsp_ready}
    task automatic build_table();
        add_row("dcr startup addr", 1'b1, `DCR_STARTUP_ADDR, 32'h0000_1000, 2,
                4'b0000, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 0, 0, 0, 0, 0, 32'h0000_1000, 32'h0);
        add_row("dcr startup arg", 1'b1, `DCR_STARTUP_ARG, 32'hcafe_0001, 2,
                4'b0000, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 0, 0, 0, 0, 0, 32'h0000_1000, 32'hcafe_0001);
        add_row("dcr unmapped", 1'b1, 12'h003, 32'hffff_ffff, 2,
                4'b0000, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 0, 0, 0, 0, 0, 32'h0000_1000, 32'hcafe_0001);
        add_row("dcr address zero", 1'b1, 12'h000, 32'h1234_5678, 1,
                4'b0000, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 0, 0, 0, 0, 0, 32'h0000_1000, 32'hcafe_0001);
        add_row("valid without ready", 1'b0, 12'h000, 32'h0, 4,
                4'b1010, 4'hf, 4'h5, 4'h0, 4'hf, 4'h0, 0, 0, 0, 0, 0, 32'h0000_1000, 32'hcafe_0001);
        add_row("ready without valid", 1'b0, 12'h000, 32'h0, 4,
                4'b0101, 4'h0, 4'h0, 4'hf, 4'h0, 4'hf, 0, 0, 0, 0, 0, 32'h0000_1000, 32'hcafe_0001);
        add_row("full fires mixed rw", 1'b0, 12'h000, 32'h0, 2,
                4'b1100, 4'hf, 4'h5, 4'hf, 4'h0, 4'h0, 2, 4, 4, 1, 2, 32'h0000_1000, 32'hcafe_0001);
        add_row("drain full fires", 1'b0, 12'h000, 32'h0, 2,
                4'b0011, 4'h0, 4'h0, 4'h0, 4'h3, 4'hf, 0, 0, 0, 3, 6, 32'h0000_1000, 32'hcafe_0001);
        add_row("read issue", 1'b0, 12'h000, 32'h0, 1,
                4'b1100, 4'hf, 4'h0, 4'hf, 4'h0, 4'h0, 1, 4, 0, 0, 0, 32'h0000_1000, 32'hcafe_0001);
        add_row("read hold", 1'b0, 12'h000, 32'h0, 3,
                4'b0000, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 0, 0, 0, 3, 12, 32'h0000_1000, 32'hcafe_0001);
        add_row("read answer", 1'b0, 12'h000, 32'h0, 1,
                4'b0011, 4'h0, 4'h0, 4'h0, 4'hf, 4'hf, 0, 0, 0, 1, 4, 32'h0000_1000, 32'hcafe_0001);
        add_row("read idle", 1'b0, 12'h000, 32'h0, 2,
                4'b0000, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 0, 0, 0, 0, 0, 32'h0000_1000, 32'hcafe_0001);
        add_random("random traffic", 600);
    endtask

    task automatic drive_cycle(input row_t r, input logic first);
        logic [31:0] rnd;
        int budget, ic_req_f, ic_rsp_f, rd_n, wr_n, rsp_n;
        dcr_write_valid = first & r.dcr_valid;
        dcr_write_addr = r.dcr_addr;
        // Cycles after the strobe carry other data, only the strobe may load it
        dcr_write_data = first ? r.dcr_data : ~r.dcr_data;
        if (r.is_random) begin
            rng_state = xorshift32(rng_state);
            rnd = rng_state;
            icache_req_valid = rnd[0];
            icache_req_ready = rnd[1];
            icache_rsp_valid = rnd[2] & (m_ipend > 0);
            icache_rsp_ready = rnd[3];
            dcache_req_valid = rnd[7:4];
            dcache_req_rw = rnd[11:8];
            dcache_req_ready = rnd[15:12];
            dcache_rsp_valid = (m_dpend > 0) ? rnd[19:16] : 4'h0;
            dcache_rsp_ready = rnd[23:20];
            // Only as many response fires as reads still outstanding
            budget = m_dpend;
            for (int i = 0; i < `DCACHE_NUM_REQS; i++) begin
                if (dcache_rsp_valid[i] && dcache_rsp_ready[i]) begin
                    if (budget > 0) budget--;
                    else dcache_rsp_valid[i] = 1'b0;
                end
            end
        end else begin
            {icache_req_valid, icache_req_ready, icache_rsp_valid, icache_rsp_ready} = r.ic;
            dcache_req_valid = r.dc_valid;
            dcache_req_rw = r.dc_rw;
            dcache_req_ready = r.dc_ready;
            dcache_rsp_valid = r.dc_rsp_valid;
            dcache_rsp_ready = r.dc_rsp_ready;
        end
        ic_req_f = int'(icache_req_valid & icache_req_ready);
        ic_rsp_f = int'(icache_rsp_valid & icache_rsp_ready);
        rd_n = $countones(dcache_req_valid & dcache_req_ready & ~dcache_req_rw);
        wr_n = $countones(dcache_req_valid & dcache_req_ready & dcache_req_rw);
        rsp_n = $countones(dcache_rsp_valid & dcache_rsp_ready);
        // Latency takes the pending count from before this edge
        m_ilat = m_ilat + core_perf_pkg::perf_ctr_t'(m_ipend);
        m_dlat = m_dlat + core_perf_pkg::perf_ctr_t'(m_dpend);
        m_ipend = m_ipend + ic_req_f - ic_rsp_f;
        m_dpend = m_dpend + rd_n - rsp_n;
        m_ifetches = m_ifetches + core_perf_pkg::perf_ctr_t'(ic_req_f);
        m_loads = m_loads + core_perf_pkg::perf_ctr_t'(rd_n);
        m_stores = m_stores + core_perf_pkg::perf_ctr_t'(wr_n);
        if (dcr_write_valid && dcr_write_addr == `DCR_STARTUP_ADDR) m_startup_addr = dcr_write_data;
        if (dcr_write_valid && dcr_write_addr == `DCR_STARTUP_ARG) m_startup_arg = dcr_write_data;
    endtask

    task automatic compare_outputs();
        check_value("perf_ifetches", 64'(perf_ifetches), 64'(m_ifetches));
        check_value("perf_loads", 64'(perf_loads), 64'(m_loads));
        check_value("perf_stores", 64'(perf_stores), 64'(m_stores));
        check_value("perf_icache_latency", 64'(perf_icache_latency), 64'(m_ilat));
        check_value("perf_dcache_latency", 64'(perf_dcache_latency), 64'(m_dlat));
        check_value("startup_addr", 64'(startup_addr), 64'(m_startup_addr));
        check_value("startup_arg", 64'(startup_arg), 64'(m_startup_arg));
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) $display("test %0d %s: ok", test_count, name);
        else $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int errors_before;
        core_perf_pkg::perf_ctr_t s_if, s_ld, s_st, s_il, s_dl;
        r = rows[idx];
        errors_before = error_count;
        {s_if, s_ld, s_st, s_il, s_dl} = {m_ifetches, m_loads, m_stores, m_ilat, m_dlat};
        for (int c = 0; c < int'(r.count); c++) begin
            drive_cycle(r, c == 0);
            @(negedge clk);
            compare_outputs();
        end
        // Hand-derived row totals against the model
        if (r.check_totals) begin
            check_value("row ifetches", 64'(m_ifetches - s_if), 64'(r.e_ifetches));
            check_value("row loads", 64'(m_loads - s_ld), 64'(r.e_loads));
            check_value("row stores", 64'(m_stores - s_st), 64'(r.e_stores));
            check_value("row icache latency", 64'(m_ilat - s_il), 64'(r.e_ilat));
            check_value("row dcache latency", 64'(m_dlat - s_dl), 64'(r.e_dlat));
            check_value("row startup_addr", 64'(m_startup_addr), 64'(r.e_addr));
            check_value("row startup_arg", 64'(m_startup_arg), 64'(r.e_arg));
        end
        report_test(row_names[idx], errors_before);
    endtask

    initial begin
        reset = 1'b1;
        dcr_write_valid = 1'b0;
        dcr_write_addr = '0;
        dcr_write_data = '0;
        {icache_req_valid, icache_req_ready, icache_rsp_valid, icache_rsp_ready} = 4'b0000;
        {dcache_req_valid, dcache_req_rw, dcache_req_ready} = '0;
        {dcache_rsp_valid, dcache_rsp_ready} = '0;
        {m_ifetches, m_loads, m_stores, m_ilat, m_dlat} = '0;
        m_startup_addr = `STARTUP_ADDR_RESET;
        m_startup_arg = '0;
        m_ipend = 0;
        m_dpend = 0;
        rng_state = 32'hbd508805;
        build_table();
        total_cycles = 3;
        foreach (rows[i]) total_cycles += int'(rows[i].count);
        watchdog_ns = longint'(total_cycles) * 20 + 1000;
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        compare_outputs();
        report_test("reset state", 0);
        foreach (rows[i]) run_row(i);
        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(watchdog_ns);
        $display("Run timed out after %0d ns before all tests finished", watchdog_ns);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== core_perf_top.f ====
+incdir+source
source/core_perf_pkg.sv
source/dcr_regs.sv
source/mem_fire_decode.sv
source/pending_read_tracker.sv
source/access_counters.sv
source/core_perf_top.sv
bench/core_perf_assert.sv
bench/core_perf_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the run by its log

verilator --binary --timing --assert --top-module core_perf_tb \
    -Mdir obj_dir -o core_perf_sim -f core_perf_top.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/core_perf_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qxF '*** PASSED ***' sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
